/* tb.f */
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_dmem.sv
design/lsu_load_align.sv
design/lsu_top.sv
verification/lsu_asserts.sv
verification/lsu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= lsu_tb
RTL_TOP    ?= lsu_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timescale 1ns/1ps

SOURCES    := $(shell cat $(FILELIST))
RTL_SRCS   := $(filter design/%,$(SOURCES))
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int MEM_BYTES   = MEM_WORDS * 4;
  localparam int DRAIN_LIMIT = 64;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic                  req_valid;
  lsu_op_e               req_op;
  logic [2:0]            req_func3;
  logic [DATA_WIDTH-1:0] req_base;
  logic [DATA_WIDTH-1:0] req_offset;
  logic [DATA_WIDTH-1:0] req_wdata;
  logic                  rsp_valid;
  logic [DATA_WIDTH-1:0] rsp_rdata;
  logic                  rsp_fault;

  logic [7:0]  ref_mem [MEM_BYTES];    // byte-wide reference memory
  logic [32:0] exp_q [$];              // {fault, rdata} per pending request
  logic [2:0]  legal_f3 [5] = '{FUNC_B, FUNC_H, FUNC_W, FUNC_BU, FUNC_HU};
  logic [31:0] lfsr = 32'h279f_11e5;
  string       test_name = "reset";
  int          test_checks = 0;
  int          test_errors = 0;
  int          total_checks = 0;
  int          total_errors = 0;
  int          tests_run = 0;

  lsu_top i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_func3  (req_func3),
    .req_base   (req_base),
    .req_offset (req_offset),
    .req_wdata  (req_wdata),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .rsp_fault  (rsp_fault)
  );

  always #10 clk = ~clk;

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // expected {fault, rdata}; stores update the byte model
  function automatic logic [32:0] lsu_ref(input lsu_op_e op, input logic [2:0] func3,
                                          input logic [31:0] base, input logic [31:0] offset,
                                          input logic [31:0] wdata);
    logic [31:0] addr;
    logic [31:0] word;
    int          nbytes;
    logic        bad;
    addr = base + offset;
    word = '0;
    case (func3)
      FUNC_B:  nbytes = 1;
      FUNC_H:  nbytes = 2;
      FUNC_W:  nbytes = 4;
      FUNC_BU: nbytes = (op == LSU_LOAD) ? 1 : 0;
      FUNC_HU: nbytes = (op == LSU_LOAD) ? 2 : 0;
      default: nbytes = 0;
    endcase
    bad = (nbytes == 0) || (addr >= MEM_BYTES);
    if (!bad) begin
      bad = (addr % nbytes) != 0;   // natural alignment
    end
    if (!bad) begin
      for (int i = 0; i < nbytes; i++) begin
        if (op == LSU_STORE) begin
          ref_mem[addr + i] = wdata[i*8 +: 8];
        end else begin
          word[i*8 +: 8] = ref_mem[addr + i];
        end
      end
      if ((op == LSU_LOAD) && ((func3 == FUNC_B) || (func3 == FUNC_H)) && word[nbytes*8-1]) begin
        for (int i = nbytes * 8; i < 32; i++) begin
          word[i] = 1'b1;
        end
      end
    end
    return {bad, word};
  endfunction

  task automatic issue(input lsu_op_e op, input logic [2:0] func3, input logic [31:0] base,
                       input logic [31:0] offset, input logic [31:0] wdata);
    @(negedge clk);
    req_valid  = 1'b1;
    req_op     = op;
    req_func3  = func3;
    req_base   = base;
    req_offset = offset;
    req_wdata  = wdata;
    if (op != LSU_NONE) begin
      exp_q.push_back(lsu_ref(op, func3, base, offset, wdata));
    end
  endtask

  task automatic drain();
    int cycles;
    @(negedge clk);
    req_valid = 1'b0;
    req_op    = LSU_NONE;
    cycles    = 0;
    while ((exp_q.size() != 0) && (cycles < DRAIN_LIMIT)) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout in test %s: %0d responses never arrived", test_name, exp_q.size());
      test_errors++;
      exp_q.delete();
    end
    repeat (4) @(negedge clk);   // window for surplus responses
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    tests_run++;
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  task automatic random_mix(input int count);
    lsu_op_e     op;
    logic [2:0]  func3;
    logic [31:0] addr;
    logic [31:0] off;
    int          size;
    for (int n = 0; n < count; n++) begin
      op    = rand_bits(1) ? LSU_LOAD : LSU_STORE;
      func3 = (op == LSU_LOAD) ? legal_f3[rand_bits(3) % 5] : legal_f3[rand_bits(2) % 3];
      size  = (func3 == FUNC_W) ? 4 : (((func3 == FUNC_B) || (func3 == FUNC_BU)) ? 1 : 2);
      addr  = rand_bits(10);
      if (rand_bits(3) != 0) begin
        addr = addr & ~(size - 1);   // mostly aligned
      end
      if (rand_bits(4) == 0) begin
        addr = addr + 32'h400;   // past the RAM
      end
      off = rand_bits(4) * 4 - 32;   // -32 .. 28
      issue(op, func3, addr - off, off, rand_bits(32));
    end
  endtask

  // response checker, sampled away from the active edge
  always @(negedge clk) begin
    logic [32:0] expected;
    if (arst_n && rsp_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("unexpected response in test %s with no request pending", test_name);
        test_errors++;
      end
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        test_checks++;
        assert ({rsp_fault, rsp_rdata} === expected) else begin
          $display("CHECK FAILED %s: expected fault=%0b rdata=%08h, actual fault=%0b rdata=%08h",
                   test_name, expected[32], expected[31:0], rsp_fault, rsp_rdata);
          test_errors++;
        end
      end
    end
  end

  initial begin
    arst_n     = 1'b1;
    req_valid  = 1'b0;
    req_op     = LSU_NONE;
    req_func3  = 3'b000;
    req_base   = '0;
    req_offset = '0;
    req_wdata  = '0;
    #2 arst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    start_test("fill");   // RAM has no reset value
    for (int w = 0; w < MEM_WORDS; w++) begin
      issue(LSU_STORE, FUNC_W, w * 4, 0, (w * 32'h9e37_79b9) ^ {w[15:0], ~w[15:0]});
    end
    drain();
    end_test();

    start_test("word_rw");
    for (int i = 0; i < 8; i++) begin
      issue(LSU_STORE, FUNC_W, 32'h100, i * 8, rand_bits(32));
      issue(LSU_LOAD, FUNC_W, 32'h100 + i * 8, 0, 0);
    end
    drain();
    end_test();

    start_test("byte_half_merge");
    for (int b = 0; b < 4; b++) begin
      issue(LSU_STORE, FUNC_B, 32'h200, b, rand_bits(32));
    end
    issue(LSU_LOAD, FUNC_W, 32'h200, 0, 0);
    issue(LSU_STORE, FUNC_H, 32'h204, 0, rand_bits(32));
    issue(LSU_STORE, FUNC_H, 32'h204, 2, rand_bits(32));
    issue(LSU_STORE, FUNC_B, 32'h205, 0, rand_bits(32));
    issue(LSU_LOAD, FUNC_W, 32'h204, 0, 0);
    drain();
    end_test();

    start_test("sign_extend");
    issue(LSU_STORE, FUNC_W, 32'h300, 0, 32'h7f80_807f);
    for (int b = 0; b < 4; b++) begin
      issue(LSU_LOAD, FUNC_B, 32'h300, b, 0);
      issue(LSU_LOAD, FUNC_BU, 32'h300, b, 0);
    end
    for (int h = 0; h < 4; h += 2) begin
      issue(LSU_LOAD, FUNC_H, 32'h300, h, 0);
      issue(LSU_LOAD, FUNC_HU, 32'h300, h, 0);
    end
    drain();
    end_test();

    start_test("fault");
    issue(LSU_LOAD, FUNC_H, 32'h301, 0, 0);
    issue(LSU_LOAD, FUNC_HU, 32'h303, 0, 0);
    issue(LSU_LOAD, FUNC_W, 32'h300, 2, 0);
    issue(LSU_STORE, FUNC_H, 32'h300, 1, 32'hdead_beef);
    issue(LSU_STORE, FUNC_W, 32'h302, 0, 32'hdead_beef);
    issue(LSU_LOAD, FUNC_W, 32'h400, 0, 0);
    issue(LSU_STORE, FUNC_W, 32'h3fc, 4, 32'hdead_beef);   // aliases word 0
    issue(LSU_STORE, FUNC_B, 32'hffff_fff0, 0, 32'h5a);    // aliases word 0x3f0
    issue(LSU_LOAD, FUNC_W, 32'h300, 0, 0);
    issue(LSU_LOAD, FUNC_W, 32'h000, 0, 0);
    issue(LSU_LOAD, FUNC_W, 32'h3f0, 0, 0);
    drain();
    end_test();

    start_test("random_mix");
    random_mix(300);
    drain();
    end_test();

    start_test("illegal_none");
    issue(LSU_LOAD, 3'b011, 32'h100, 0, 0);
    issue(LSU_NONE, FUNC_W, 32'h100, 0, 32'hffff_ffff);
    issue(LSU_LOAD, 3'b110, 32'h100, 0, 0);
    issue(LSU_STORE, FUNC_BU, 32'h100, 0, 32'hffff_ffff);
    issue(LSU_NONE, FUNC_B, 32'h104, 0, 32'hffff_ffff);
    issue(LSU_STORE, FUNC_HU, 32'h100, 0, 32'hffff_ffff);
    issue(LSU_STORE, 3'b011, 32'h100, 0, 32'hffff_ffff);
    issue(LSU_LOAD, 3'b111, 32'h100, 0, 0);
    issue(LSU_LOAD, FUNC_W, 32'h100, 0, 0);
    issue(LSU_NONE, FUNC_W, 32'h100, 0, 0);   // last slot stays silent
    drain();
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/lsu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts (
  input logic                           clk,
  input logic                           arst_n,
  input logic                           req_valid,
  input lsu_pkg::lsu_op_e               req_op,
  input logic                           s1_valid,
  input logic                           s2_valid,
  input logic                           rsp_valid,
  input logic [lsu_pkg::DATA_WIDTH-1:0] rsp_rdata,
  input logic                           rsp_fault
);
  import lsu_pkg::*;

  logic accepted;

  assign accepted = req_valid && (req_op != LSU_NONE);   // none strobes never answer

  rsp_latency: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid == $past(accepted, 3))
    else $error("rsp_valid does not match a request three cycles earlier");

  reset_quiet: assert property (@(posedge clk)
    !arst_n |-> !(s1_valid || s2_valid || rsp_valid))
    else $error("valid signal high while reset is asserted");

  fault_zero: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_fault |-> (rsp_rdata == '0))
    else $error("faulting response carries nonzero data");

endmodule

bind lsu_top lsu_asserts i_asserts (
  .clk       (clk),
  .arst_n    (arst_n),
  .req_valid (req_valid),
  .req_op    (req_op),
  .s1_valid  (s1_valid),
  .s2_valid  (s2_valid),
  .rsp_valid (rsp_valid),
  .rsp_rdata (rsp_rdata),
  .rsp_fault (rsp_fault)
);

`default_nettype wire

/* design/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           req_valid,
  input  lsu_pkg::lsu_op_e               req_op,
  input  logic [2:0]                     req_func3,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] req_base,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] req_offset,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] req_wdata,
  output logic                           rsp_valid,
  output logic [lsu_pkg::DATA_WIDTH-1:0] rsp_rdata,
  output logic                           rsp_fault
);
  import lsu_pkg::*;

  // stage 1 -> stage 2
  logic                     s1_valid;
  lsu_op_e                  s1_op;
  logic [2:0]               s1_func3;
  logic                     s1_fault;
  logic [MEM_IDX_WIDTH-1:0] s1_word_idx;
  logic [1:0]               s1_byte_off;
  logic [3:0]               s1_wmask;
  logic [DATA_WIDTH-1:0]    s1_wdata;

  // stage 2 -> stage 3
  logic                     s2_valid;
  lsu_op_e                  s2_op;
  logic [2:0]               s2_func3;
  logic                     s2_fault;
  logic [1:0]               s2_byte_off;
  logic [DATA_WIDTH-1:0]    s2_rdata;

  lsu_agu u_agu (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_func3   (req_func3),
    .req_base    (req_base),
    .req_offset  (req_offset),
    .req_wdata   (req_wdata),
    .s1_valid    (s1_valid),
    .s1_op       (s1_op),
    .s1_func3    (s1_func3),
    .s1_fault    (s1_fault),
    .s1_word_idx (s1_word_idx),
    .s1_byte_off (s1_byte_off),
    .s1_wmask    (s1_wmask),
    .s1_wdata    (s1_wdata)
  );

  lsu_dmem u_dmem (
    .clk         (clk),
    .arst_n      (arst_n),
    .s1_valid    (s1_valid),
    .s1_op       (s1_op),
    .s1_func3    (s1_func3),
    .s1_fault    (s1_fault),
    .s1_word_idx (s1_word_idx),
    .s1_byte_off (s1_byte_off),
    .s1_wmask    (s1_wmask),
    .s1_wdata    (s1_wdata),
    .s2_valid    (s2_valid),
    .s2_op       (s2_op),
    .s2_func3    (s2_func3),
    .s2_fault    (s2_fault),
    .s2_byte_off (s2_byte_off),
    .s2_rdata    (s2_rdata)
  );

  lsu_load_align u_load_align (
    .clk         (clk),
    .arst_n      (arst_n),
    .s2_valid    (s2_valid),
    .s2_op       (s2_op),
    .s2_func3    (s2_func3),
    .s2_fault    (s2_fault),
    .s2_byte_off (s2_byte_off),
    .s2_rdata    (s2_rdata),
    .rsp_valid   (rsp_valid),
    .rsp_rdata   (rsp_rdata),
    .rsp_fault   (rsp_fault)
  );

endmodule

`default_nettype wire

/* design/lsu_load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           s2_valid,
  input  lsu_pkg::lsu_op_e               s2_op,
  input  logic [2:0]                     s2_func3,
  input  logic                           s2_fault,
  input  logic [1:0]                     s2_byte_off,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] s2_rdata,
  output logic                           rsp_valid,
  output logic [lsu_pkg::DATA_WIDTH-1:0] rsp_rdata,
  output logic                           rsp_fault
);
  import lsu_pkg::*;

  logic [DATA_WIDTH-1:0] shifted;
  logic [DATA_WIDTH-1:0] extended;
  logic [DATA_WIDTH-1:0] result;

  assign shifted = s2_rdata >> {s2_byte_off, 3'b000};   // addressed byte to lane 0

  always_comb begin
    case (s2_func3)
      FUNC_B:  extended = {{24{shifted[7]}}, shifted[7:0]};
      FUNC_H:  extended = {{16{shifted[15]}}, shifted[15:0]};
      FUNC_W:  extended = shifted;
      FUNC_BU: extended = {24'h0, shifted[7:0]};
      FUNC_HU: extended = {16'h0, shifted[15:0]};
      default: extended = '0;
    endcase
  end

  // stores and faults return zero
  assign result = ((s2_op == LSU_LOAD) && !s2_fault) ? extended : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp_rdata <= result;
    rsp_fault <= s2_valid & s2_fault;
  end

endmodule

`default_nettype wire

/* design/lsu_dmem.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_dmem (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              s1_valid,
  input  lsu_pkg::lsu_op_e                  s1_op,
  input  logic [2:0]                        s1_func3,
  input  logic                              s1_fault,
  input  logic [lsu_pkg::MEM_IDX_WIDTH-1:0] s1_word_idx,
  input  logic [1:0]                        s1_byte_off,
  input  logic [3:0]                        s1_wmask,
  input  logic [lsu_pkg::DATA_WIDTH-1:0]    s1_wdata,
  output logic                              s2_valid,
  output lsu_pkg::lsu_op_e                  s2_op,
  output logic [2:0]                        s2_func3,
  output logic                              s2_fault,
  output logic [1:0]                        s2_byte_off,
  output logic [lsu_pkg::DATA_WIDTH-1:0]    s2_rdata
);
  import lsu_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic                  wr_en;

  assign wr_en = s1_valid && (s1_op == LSU_STORE) && !s1_fault;

  // byte-lane write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (s1_wmask[i]) begin
          mem[s1_word_idx][i*8 +: 8] <= s1_wdata[i*8 +: 8];
        end
      end
    end
  end

  // synchronous read, one access per cycle so no same-slot conflict
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_rdata <= mem[s1_word_idx];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_op       <= s1_op;
    s2_func3    <= s1_func3;
    s2_fault    <= s1_fault;
    s2_byte_off <= s1_byte_off;
  end

endmodule

`default_nettype wire

/* design/lsu_agu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              req_valid,
  input  lsu_pkg::lsu_op_e                  req_op,
  input  logic [2:0]                        req_func3,
  input  logic [lsu_pkg::DATA_WIDTH-1:0]    req_base,
  input  logic [lsu_pkg::DATA_WIDTH-1:0]    req_offset,
  input  logic [lsu_pkg::DATA_WIDTH-1:0]    req_wdata,
  output logic                              s1_valid,
  output lsu_pkg::lsu_op_e                  s1_op,
  output logic [2:0]                        s1_func3,
  output logic                              s1_fault,
  output logic [lsu_pkg::MEM_IDX_WIDTH-1:0] s1_word_idx,
  output logic [1:0]                        s1_byte_off,
  output logic [3:0]                        s1_wmask,
  output logic [lsu_pkg::DATA_WIDTH-1:0]    s1_wdata
);
  import lsu_pkg::*;

  logic [DATA_WIDTH-1:0] addr;
  logic                  misalign;
  logic                  out_of_range;
  logic                  bad_func;
  logic                  fault;
  logic [3:0]            mask_base;
  logic [DATA_WIDTH-1:0] wdata_rep;

  assign addr         = req_base + req_offset;
  assign out_of_range = addr >= DATA_WIDTH'(MEM_WORDS * 4);
  assign fault        = misalign | out_of_range | bad_func;

  // width decode, lane replication and alignment check
  always_comb begin
    mask_base = 4'b0000;
    wdata_rep = req_wdata;
    misalign  = 1'b0;
    bad_func  = 1'b0;
    case (req_func3)
      FUNC_B: begin
        mask_base = 4'b0001;
        wdata_rep = {4{req_wdata[7:0]}};
      end
      FUNC_H: begin
        mask_base = 4'b0011;
        wdata_rep = {2{req_wdata[15:0]}};
        misalign  = addr[0];
      end
      FUNC_W: begin
        mask_base = 4'b1111;
        misalign  = |addr[1:0];
      end
      FUNC_BU: begin
        bad_func = (req_op == LSU_STORE);   // no unsigned store
      end
      FUNC_HU: begin
        bad_func = (req_op == LSU_STORE);
        misalign = addr[0];
      end
      default: begin
        bad_func = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid && (req_op != LSU_NONE);   // none strobes dropped here
    end
  end

  always_ff @(posedge clk) begin
    s1_op       <= req_op;
    s1_func3    <= req_func3;
    s1_fault    <= fault;
    s1_word_idx <= addr[MEM_IDX_WIDTH+1:2];
    s1_byte_off <= addr[1:0];
    s1_wdata    <= wdata_rep;
    if ((req_op == LSU_STORE) && !fault) begin
      s1_wmask <= mask_base << addr[1:0];
    end else begin
      s1_wmask <= 4'b0000;   // loads and faults touch nothing
    end
  end

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // word and address width
  localparam int DATA_WIDTH = 32;

  // data RAM geometry
  localparam int MEM_WORDS     = 256;
  localparam int MEM_IDX_WIDTH = $clog2(MEM_WORDS);   // 8 for 256 words

  // operation carried with each request strobe
  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,    // strobe is dropped
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_e;

  // RV32I func3 width codes for loads and stores
  localparam logic [2:0] FUNC_B  = 3'b000;   // lb / sb
  localparam logic [2:0] FUNC_H  = 3'b001;   // lh / sh
  localparam logic [2:0] FUNC_W  = 3'b010;   // lw / sw
  localparam logic [2:0] FUNC_BU = 3'b100;   // lbu, load only
  localparam logic [2:0] FUNC_HU = 3'b101;   // lhu, load only

endpackage

`default_nettype wire
